//--- verilog.f
+incdir+source
+incdir+bench
source/aes_key_pkg.sv
source/aes_key_word_select.sv
source/aes_sub_word_buffer.sv
source/aes_key_mix.sv
source/aes_key_expand.sv
bench/aes_key_expand_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the key expansion testbench with Verilator.
# The run passes only if the log holds the pass line.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --assert \
  -f verilog.f \
  --top-module aes_key_expand_tb \
  -o aes_key_expand_sim

./obj_dir/aes_key_expand_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^NO ERRORS$" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

//--- bench/tb_key_model.svh
/*
  Reference model for the key expansion testbench.
  Included inside the testbench module, uses its lfsr_state variable.
*/
`ifndef TB_KEY_MODEL_SVH
`define TB_KEY_MODEL_SVH

// Galois LFSR, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(logic [31:0] s);
  return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// One LFSR step per bit taken, first bit ends up on top
function automatic logic [31:0] rand_bits(int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    v = {v[30:0], lfsr_state[0]};
    lfsr_state = lfsr_next(lfsr_state);
  end
  return v;
endfunction

// GF(2^8) doubling for Rcon
function automatic aes_rcon_t xtime(aes_rcon_t b);
  return b[7] ? ({b[6:0], 1'b0} ^ 8'h1b) : {b[6:0], 1'b0};
endfunction

// Rcon one step back, by search
function automatic aes_rcon_t rcon_back(aes_rcon_t b);
  for (int v = 0; v < 256; v++) begin
    if (xtime(aes_rcon_t'(v)) == b) return aes_rcon_t'(v);
  end
  return '0;
endfunction

// Next full key from the current one
function automatic aes_key_t next_key(ciph_op_e op, key_len_e len, logic [3:0] rnd,
                                      aes_key_t k, aes_rcon_t rc);
  aes_key_t  n;
  aes_word_t w;
  aes_word_t r;
  logic      use_rc;
  use_rc = (len == AES_128) || rnd[0];
  n = k;
  // Round 0 of AES-256 only swaps halves
  if (len == AES_256 && rnd == 4'd0) begin
    for (int i = 0; i < 4; i++) begin
      n[i]     = k[i + 4];
      n[i + 4] = k[i];
    end
    return n;
  end
  if (len == AES_128) w = (op == CIPH_FWD) ? k[3] : (k[3] ^ k[2]);
  else w = (op == CIPH_FWD) ? k[7] : k[3];
  // RotWord then SubWord, byte by byte
  for (int i = 0; i < 4; i++) begin
    r[i] = use_rc ? w[(i + 1) % 4] : w[i];
  end
  for (int i = 0; i < 4; i++) begin
    r[i] = aes_sbox_lut(r[i]);
  end
  if (use_rc) r[0] = r[0] ^ rc;
  if (len == AES_128) begin
    for (int i = 0; i < 4; i++) n[i + 4] = k[i];
    n[0] = r ^ k[0];
    for (int i = 1; i < 4; i++) begin
      n[i] = (op == CIPH_FWD) ? (n[i - 1] ^ k[i]) : (k[i - 1] ^ k[i]);
    end
  end else if (op == CIPH_FWD) begin
    for (int i = 0; i < 4; i++) n[i] = k[i + 4];
    n[4] = r ^ k[0];
    for (int i = 1; i < 4; i++) n[i + 4] = n[i + 3] ^ k[i];
  end else begin
    for (int i = 0; i < 4; i++) n[i + 4] = k[i];
    n[0] = r ^ k[4];
    for (int i = 0; i < 3; i++) n[i + 1] = k[4 + i] ^ k[5 + i];
  end
  return n;
endfunction

`endif

//--- bench/aes_key_expand_tb.sv
/*
  Testbench for the key expansion top level.
  Inputs change 1 ns after the rising edge, outputs are sampled at the falling edge.
  Each item is fully acknowledged before the next en_i.
*/
`timescale 1ns/1ns
`include "aes_key_defs.svh"

module aes_key_expand_tb;
  import aes_key_pkg::*;

  localparam int WAIT_LIMIT = 20;

  logic        clk_i = 1'b0;
  logic        rst_ni;
  ciph_op_e    op_i;
  key_len_e    key_len_i;
  logic [3:0]  round_i;
  aes_key_t    key_i;
  logic        en_i;
  logic        clear_i;
  logic        out_ack_i;
  aes_key_t    key_o;
  logic        out_req_o;

  logic [31:0] lfsr_state = 32'h47aa_0c2e;
  aes_rcon_t   rcon;
  int          key_errs;
  int          req_errs;
  int          other_errs;

  `include "tb_key_model.svh"

  aes_key_expand aes_key_expand_i (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .op_i      (op_i),
    .key_len_i (key_len_i),
    .round_i   (round_i),
    .key_i     (key_i),
    .en_i      (en_i),
    .clear_i   (clear_i),
    .out_ack_i (out_ack_i),
    .key_o     (key_o),
    .out_req_o (out_req_o)
  );

  always #2 clk_i = ~clk_i;

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  task automatic check_key(input string name, input aes_key_t exp, input aes_key_t act);
    if (exp !== act) begin
      $display("mismatch %s expected %h actual %h", name, exp, act);
      key_errs++;
    end
  endtask

  task automatic check_req(input string name, input bit exp, input logic act);
    if (act !== exp) begin
      $display("mismatch %s expected %b actual %b", name, exp, act);
      req_errs++;
    end
  endtask

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  // FIPS words are written first byte on the left
  function automatic aes_word_t fips_word(logic [31:0] w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  function automatic aes_key_t rand_key(int words);
    aes_key_t k;
    k = '0;
    for (int i = 0; i < words; i++) k[i] = rand_bits(32);
    return k;
  endfunction

  // Pulse clear and reseed the tracked Rcon
  task automatic clear_rcon(input ciph_op_e op, input key_len_e len);
    op_i = op;
    key_len_i = len;
    clear_i = 1'b1;
    @(posedge clk_i);
    #1;
    clear_i = 1'b0;
    if (op == CIPH_FWD) rcon = `AES_RCON_FWD_INIT;
    else if (len == AES_128) rcon = `AES_RCON_INV128_INIT;
    else rcon = `AES_RCON_INV256_INIT;
  endtask

  // Rcon moves only on rounds that use it
  task automatic track_rcon(input ciph_op_e op, input key_len_e len, input logic [3:0] rnd);
    if (len == AES_128 || rnd[0]) rcon = (op == CIPH_FWD) ? xtime(rcon) : rcon_back(rcon);
  endtask

  // One full request, optional stall, then the ack
  task automatic run_round(input string name, input ciph_op_e op, input key_len_e len,
                           input logic [3:0] rnd, input aes_key_t key, input int stall,
                           input bit hold_ack, output aes_key_t exp, output aes_key_t got);
    int cnt;
    exp = next_key(op, len, rnd, key, rcon);
    got = '0;
    op_i = op;
    key_len_i = len;
    round_i = rnd;
    key_i = key;
    en_i = 1'b1;
    out_ack_i = hold_ack;
    cnt = 0;
    do begin
      @(posedge clk_i);
      #1;
      cnt++;
    end while (!out_req_o && cnt < WAIT_LIMIT);
    en_i = 1'b0;
    if (!out_req_o) begin
      $display("timeout in %s: out_req_o never went high", name);
      other_errs++;
      return;
    end
    if (cnt != 1) begin
      $display("%s: out_req_o rose after %0d cycles instead of 1", name, cnt);
      other_errs++;
    end
    // Stalled cycles must keep the result
    for (int s = 0; s < stall; s++) begin
      out_ack_i = 1'b0;
      @(negedge clk_i);
      check_req(name, 1'b1, out_req_o);
      check_key(name, exp, key_o);
      @(posedge clk_i);
      #1;
    end
    out_ack_i = 1'b1;
    @(negedge clk_i);
    check_req(name, 1'b1, out_req_o);
    check_key(name, exp, key_o);
    got = key_o;
    @(posedge clk_i);
    #1;
    out_ack_i = hold_ack;
    check_req(name, 1'b0, out_req_o);
    track_rcon(op, len, rnd);
  endtask

  // Chain of rounds, each fed the previous expected key
  task automatic run_chain(input string name, input ciph_op_e op, input key_len_e len,
                           input int first, input int last, input bit stalls,
                           input bit hold_ack, inout aes_key_t key);
    aes_key_t exp;
    aes_key_t got;
    int       step;
    int       stall;
    step = (last >= first) ? 1 : -1;
    for (int r = first; r != last + step; r += step) begin
      stall = stalls ? int'(rand_bits(3)) + 1 : 0;
      run_round(name, op, len, 4'(r), key, stall, hold_ack, exp, got);
      // Round 0 of AES-256 is a plain half swap
      if (len == AES_256 && r == 0) begin
        check_key({name, "_swap"}, {key[3:0], key[7:4]}, got);
      end
      key = exp;
    end
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin : main
    aes_key_t k0;
    aes_key_t k;
    aes_key_t tmp;
    aes_rcon_t rc;
    key_errs = 0;
    req_errs = 0;
    other_errs = 0;
    rst_ni = 1'b0;
    op_i = CIPH_FWD;
    key_len_i = AES_128;
    round_i = '0;
    key_i = '0;
    en_i = 1'b0;
    clear_i = 1'b0;
    out_ack_i = 1'b0;
    rcon = '0;
    repeat (3) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // Idle after reset
    repeat (2) begin
      @(negedge clk_i);
      check_req("reset_idle", 1'b0, out_req_o);
    end
    @(posedge clk_i);
    #1;

    // AES-128 forward from the FIPS-197 key
    k = '0;
    k[0] = fips_word(32'h2b7e1516);
    k[1] = fips_word(32'h28aed2a6);
    k[2] = fips_word(32'habf71588);
    k[3] = fips_word(32'h09cf4f3c);
    clear_rcon(CIPH_FWD, AES_128);
    run_chain("aes128_fwd", CIPH_FWD, AES_128, 1, 10, 1'b0, 1'b0, k);
    tmp = k;
    tmp[0] = fips_word(32'hd014f9a8);
    tmp[1] = fips_word(32'hc9ee2589);
    tmp[2] = fips_word(32'he13f0cc8);
    tmp[3] = fips_word(32'hb6630ca6);
    check_key("aes128_last_key", tmp, k);

    // AES-128 inverse, back to a model-built start key
    k0 = rand_key(4);
    k = k0;
    rc = `AES_RCON_FWD_INIT;
    for (int r = 1; r <= 10; r++) begin
      k = next_key(CIPH_FWD, AES_128, 4'(r), k, rc);
      rc = xtime(rc);
    end
    clear_rcon(CIPH_INV, AES_128);
    run_chain("aes128_inv", CIPH_INV, AES_128, 10, 1, 1'b0, 1'b0, k);
    tmp = k;
    tmp[3:0] = k0[3:0];
    check_key("aes128_inv_start", tmp, k);

    // AES-256 both directions, round 0 swap included
    k = rand_key(8);
    clear_rcon(CIPH_FWD, AES_256);
    run_chain("aes256_fwd", CIPH_FWD, AES_256, 0, 14, 1'b0, 1'b0, k);
    k = rand_key(8);
    clear_rcon(CIPH_INV, AES_256);
    run_chain("aes256_inv", CIPH_INV, AES_256, 0, 14, 1'b0, 1'b0, k);

    // Back-pressure with random stall spans
    k = rand_key(4);
    clear_rcon(CIPH_FWD, AES_128);
    run_chain("stall_128", CIPH_FWD, AES_128, 1, 10, 1'b1, 1'b0, k);
    k = rand_key(8);
    clear_rcon(CIPH_INV, AES_256);
    run_chain("stall_256", CIPH_INV, AES_256, 0, 14, 1'b1, 1'b0, k);

    // Ack held high, each request right after the last handshake
    k = rand_key(8);
    clear_rcon(CIPH_FWD, AES_256);
    run_chain("b2b_256", CIPH_FWD, AES_256, 0, 14, 1'b0, 1'b1, k);
    out_ack_i = 1'b0;

    $display("checks done: %0d key errors, %0d req errors, %0d other errors",
             key_errs, req_errs, other_errs);
    if (key_errs + req_errs + other_errs == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- source/aes_key_expand.sv
/*
  Top level of the round-key expansion, instances and wiring only.
  key_i, op_i, key_len_i and round_i must be held from en_i until the ack.
  clear_i is a one-cycle pulse given while out_req_o is low.
*/
`timescale 1ns/1ns

module aes_key_expand (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  aes_key_pkg::ciph_op_e op_i,
  input  aes_key_pkg::key_len_e key_len_i,
  input  logic [3:0]            round_i,
  input  aes_key_pkg::aes_key_t key_i,
  input  logic                  en_i,
  input  logic                  clear_i,
  input  logic                  out_ack_i,
  output aes_key_pkg::aes_key_t key_o,
  output logic                  out_req_o
);
  import aes_key_pkg::*;

  // Producer to buffer
  aes_word_t rot_in;
  // Producer to consumer
  aes_rcon_t rcon;
  logic      use_rcon;
  // Buffer to consumer
  aes_word_t sub_word;

  //////////////////////////////
  // Stages
  //////////////////////////////

  // Word choice and Rcon
  aes_key_word_select u_word_select (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .op_i       (op_i),
    .key_len_i  (key_len_i),
    .round_i    (round_i),
    .key_i      (key_i),
    .clear_i    (clear_i),
    .out_req_i  (out_req_o),
    .out_ack_i  (out_ack_i),
    .rot_in_o   (rot_in),
    .rcon_o     (rcon),
    .use_rcon_o (use_rcon)
  );

  // SubWord, registered
  aes_sub_word_buffer u_sub_word_buffer (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .en_i       (en_i),
    .out_ack_i  (out_ack_i),
    .rot_in_i   (rot_in),
    .sub_word_o (sub_word),
    .out_req_o  (out_req_o)
  );

  // Next key words
  aes_key_mix u_key_mix (
    .op_i       (op_i),
    .key_len_i  (key_len_i),
    .round_i    (round_i),
    .key_i      (key_i),
    .sub_word_i (sub_word),
    .rcon_i     (rcon),
    .use_rcon_i (use_rcon),
    .key_o      (key_o)
  );

endmodule

//--- source/aes_key_mix.sv
/*
  Consumer stage, purely combinational.
  Builds the next full key from the current key and the buffered SubWord.
  For AES-128 the upper half of key_o carries the old lower half.
*/
`timescale 1ns/1ns
`include "aes_key_defs.svh"

module aes_key_mix (
  input  aes_key_pkg::ciph_op_e  op_i,
  input  aes_key_pkg::key_len_e  key_len_i,
  input  logic [3:0]             round_i,
  input  aes_key_pkg::aes_key_t  key_i,
  input  aes_key_pkg::aes_word_t sub_word_i,
  input  aes_key_pkg::aes_rcon_t rcon_i,
  input  logic                   use_rcon_i,
  output aes_key_pkg::aes_key_t  key_o
);
  import aes_key_pkg::*;

  localparam int HALF_WORDS = `AES_KEY_WORDS / 2;

  aes_word_t irregular;

  //////////////////////////////
  // Irregular word
  //////////////////////////////

  // Rcon goes into byte 0 only
  assign irregular = use_rcon_i ? {sub_word_i[3:1], sub_word_i[0] ^ rcon_i} : sub_word_i;

  //////////////////////////////
  // XOR chains
  //////////////////////////////

  always_comb begin : mix_words
    aes_word_t acc;
    acc   = irregular;
    key_o = key_i;
    unique case (key_len_i)
      AES_128: begin
        // Upper half unused, keeps the old lower half
        key_o[`AES_KEY_WORDS-1:HALF_WORDS] = key_i[HALF_WORDS-1:0];
        key_o[0] = irregular ^ key_i[0];
        if (op_i == CIPH_FWD) begin
          // Running XOR across the four words
          for (int i = 0; i < HALF_WORDS; i++) begin
            acc      = acc ^ key_i[i];
            key_o[i] = acc;
          end
        end else begin
          // Going back, neighbours of the old key suffice
          for (int i = 1; i < HALF_WORDS; i++) begin
            key_o[i] = key_i[i-1] ^ key_i[i];
          end
        end
      end
      AES_256: begin
        if (round_i == 4'd0) begin
          // Round 0 just swaps the halves
          key_o = {key_i[HALF_WORDS-1:0], key_i[`AES_KEY_WORDS-1:HALF_WORDS]};
        end else if (op_i == CIPH_FWD) begin
          // Old upper half drops down
          key_o[HALF_WORDS-1:0] = key_i[`AES_KEY_WORDS-1:HALF_WORDS];
          // New upper half from the chain
          for (int i = 0; i < HALF_WORDS; i++) begin
            acc                   = acc ^ key_i[i];
            key_o[i + HALF_WORDS] = acc;
          end
        end else begin
          // Old lower half moves up
          key_o[`AES_KEY_WORDS-1:HALF_WORDS] = key_i[HALF_WORDS-1:0];
          key_o[0] = irregular ^ key_i[HALF_WORDS];
          for (int i = 0; i < HALF_WORDS - 1; i++) begin
            key_o[i+1] = key_i[HALF_WORDS+i] ^ key_i[HALF_WORDS+i+1];
          end
        end
      end
    endcase
  end

endmodule

//--- source/aes_sub_word_buffer.sv
/*
  SubWord stage with a one-entry output register.
  Result appears one cycle after en_i is taken and holds until out_ack_i.
*/
`timescale 1ns/1ns
`include "aes_key_defs.svh"

module aes_sub_word_buffer (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   en_i,
  input  logic                   out_ack_i,
  input  aes_key_pkg::aes_word_t rot_in_i,
  output aes_key_pkg::aes_word_t sub_word_o,
  output logic                   out_req_o
);
  import aes_key_pkg::*;

  aes_word_t sub_word_d;
  aes_word_t sub_word_q;
  logic      full_q;
  logic      load;

  //////////////////////////////
  // Byte substitution
  //////////////////////////////

  // One table lookup per byte
  always_comb begin : sub_bytes
    for (int i = 0; i < `AES_WORD_W/`AES_BYTE_W; i++) begin
      sub_word_d[i] = aes_sbox_lut(rot_in_i[i]);
    end
  end

  //////////////////////////////
  // Output register
  //////////////////////////////

  // Accept when empty, or when the current entry leaves this cycle
  assign load = en_i & (~full_q | out_ack_i);

  // Full flag
  always_ff @(posedge clk_i or negedge rst_ni) begin : full_reg
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (load) begin
      full_q <= 1'b1;
    end else if (out_ack_i) begin
      full_q <= 1'b0;
    end
  end

  // Payload, only meaningful while full
  always_ff @(posedge clk_i) begin : data_reg
    if (load) begin
      sub_word_q <= sub_word_d;
    end
  end

  assign sub_word_o = sub_word_q;
  assign out_req_o  = full_q;

  // Stalled result must not move
  hold_on_stall_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (out_req_o && !out_ack_i) |=> $stable(sub_word_o));

endmodule

//--- source/aes_key_word_select.sv
/*
  Producer stage of the key expansion.
  Picks the RotWord source word and owns the Rcon register.
  op_i and key_len_i must stay stable while a request is pending.
*/
`timescale 1ns/1ns
`include "aes_key_defs.svh"

module aes_key_word_select (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  aes_key_pkg::ciph_op_e  op_i,
  input  aes_key_pkg::key_len_e  key_len_i,
  input  logic [3:0]             round_i,
  input  aes_key_pkg::aes_key_t  key_i,
  input  logic                   clear_i,
  input  logic                   out_req_i,
  input  logic                   out_ack_i,
  output aes_key_pkg::aes_word_t rot_in_o,
  output aes_key_pkg::aes_rcon_t rcon_o,
  output logic                   use_rcon_o
);
  import aes_key_pkg::*;

  aes_word_t sel_word;
  logic      use_rot;
  logic      rcon_adv;
  aes_rcon_t rcon_d, rcon_q;

  //////////////////////////////
  // Word selection
  //////////////////////////////

  // Even AES-256 rounds skip RotWord and Rcon alike
  assign use_rot    = !(key_len_i == AES_256 && !round_i[0]);
  assign use_rcon_o = use_rot;

  always_comb begin : sel_src
    unique case (key_len_i)
      // Inverse AES-128 needs the XOR of words 3 and 2
      AES_128: sel_word = (op_i == CIPH_FWD) ? key_i[3] : (key_i[3] ^ key_i[2]);
      AES_256: sel_word = (op_i == CIPH_FWD) ? key_i[7] : key_i[3];
    endcase
  end

  assign rot_in_o = use_rot ? aes_rot_word(sel_word) : sel_word;

  //////////////////////////////
  // Rcon register
  //////////////////////////////

  // Steps only on a completed handshake of a round that uses Rcon
  assign rcon_adv = use_rcon_o & out_req_i & out_ack_i;

  always_comb begin : rcon_next
    rcon_d = rcon_q;
    if (clear_i) begin
      // Seed depends on direction and, going back, on key length
      if (op_i == CIPH_FWD) begin
        rcon_d = `AES_RCON_FWD_INIT;
      end else if (key_len_i == AES_128) begin
        rcon_d = `AES_RCON_INV128_INIT;
      end else begin
        rcon_d = `AES_RCON_INV256_INIT;
      end
    end else if (rcon_adv) begin
      rcon_d = (op_i == CIPH_FWD) ? aes_mul2(rcon_q) : aes_div2(rcon_q);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : rcon_reg
    if (!rst_ni) begin
      rcon_q <= '0;
    end else begin
      rcon_q <= rcon_d;
    end
  end

  assign rcon_o = rcon_q;

  // Once seeded, doubling or halving in GF(2^8) never reaches zero
  rcon_nonzero_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (clear_i || rcon_q != '0) |=> (rcon_q != '0));

  // Config must be known while the result is offered
  cfg_known_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      out_req_i |-> !$isunknown({op_i, key_len_i}));

endmodule

//--- source/aes_key_pkg.sv
/*
  Types and helper functions of the key expansion unit.
  Byte 0 sits in the low bits of a word, word 0 in the low bits of a key.
  The S-box is a plain lookup table with no side-channel protection.
*/
`include "aes_key_defs.svh"

package aes_key_pkg;

  //////////////////////////////
  // Types
  //////////////////////////////

  // Direction of the expansion
  typedef enum logic {
    CIPH_FWD = 1'b0,
    CIPH_INV = 1'b1
  } ciph_op_e;

  // Supported key lengths
  typedef enum logic {
    AES_128 = 1'b0,
    AES_256 = 1'b1
  } key_len_e;

  // Four bytes per word
  typedef logic [`AES_WORD_W/`AES_BYTE_W-1:0][`AES_BYTE_W-1:0] aes_word_t;
  typedef aes_word_t [`AES_KEY_WORDS-1:0] aes_key_t;
  typedef logic [`AES_BYTE_W-1:0] aes_rcon_t;

  //////////////////////////////
  // S-box table
  //////////////////////////////

  // Entry 0 in the top byte, one row of 16 entries per line
  localparam logic [2047:0] SBOX_TABLE = {
    128'h637c777bf26b6fc53001672bfed7ab76,
    128'hca82c97dfa5947f0add4a2af9ca472c0,
    128'hb7fd9326363ff7cc34a5e5f171d83115,
    128'h04c723c31896059a071280e2eb27b275,
    128'h09832c1a1b6e5aa0523bd6b329e32f84,
    128'h53d100ed20fcb15b6acbbe394a4c58cf,
    128'hd0efaafb434d338545f9027f503c9fa8,
    128'h51a3408f929d38f5bcb6da2110fff3d2,
    128'hcd0c13ec5f974417c4a77e3d645d1973,
    128'h60814fdc222a908846eeb814de5e0bdb,
    128'he0323a0a4906245cc2d3ac629195e479,
    128'he7c8376d8dd54ea96c56f4ea657aae08,
    128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
    128'h703eb5664803f60e613557b986c11d9e,
    128'he1f8981169d98e949b1e87e9ce5528df,
    128'h8ca1890dbfe6426841992d0fb054bb16
  };

  //////////////////////////////
  // Functions
  //////////////////////////////

  // Forward byte substitution
  function automatic logic [`AES_BYTE_W-1:0] aes_sbox_lut(logic [`AES_BYTE_W-1:0] b);
    int idx;
    // Table is written MSB first
    idx = 255 - int'(b);
    return SBOX_TABLE[8*idx +: 8];
  endfunction

  // Multiply by x, reduce by 0x11b
  function automatic aes_rcon_t aes_mul2(aes_rcon_t b);
    aes_rcon_t shifted;
    shifted = {b[6:0], 1'b0};
    return b[7] ? (shifted ^ 8'h1b) : shifted;
  endfunction

  // Undo aes_mul2
  // An odd value means the top bit overflowed and 0x1b was folded in
  function automatic aes_rcon_t aes_div2(aes_rcon_t b);
    aes_rcon_t unfolded;
    unfolded = b[0] ? (b ^ 8'h1b) : b;
    return {b[0], unfolded[7:1]};
  endfunction

  // RotWord, byte 1 moves down to byte 0
  function automatic aes_word_t aes_rot_word(aes_word_t w);
    return {w[0], w[3], w[2], w[1]};
  endfunction

endpackage

//--- source/aes_key_defs.svh
/*
  Fixed AES key expansion sizes and Rcon start values.
  Only AES-128 and AES-256 are covered, so the key register is always 8 words.
*/
`ifndef AES_KEY_DEFS_SVH
`define AES_KEY_DEFS_SVH

// Full key register holds 8 words, AES-128 uses the low half only
`define AES_KEY_WORDS 8

// Word and byte widths fixed by the standard
`define AES_WORD_W 32
`define AES_BYTE_W 8

// Rcon seed for forward expansion
`define AES_RCON_FWD_INIT 8'h01

// Rcon seeds for stepping back from the last round key
// 0x36 is Rcon of round 10, 0x40 is Rcon of round 7
`define AES_RCON_INV128_INIT 8'h36
`define AES_RCON_INV256_INIT 8'h40

`endif
